// ==== mvm_accel.f ====
+incdir+sim
src/mvm_pkg.sv
src/vector_fifo.sv
src/weight_rf.sv
src/inst_sequencer.sv
src/dpe_array.sv
src/tx_credit_port.sv
src/mvm_top.sv
sim/tb_mvm.sv

// ==== Bender.yml ====
package:
  name: mvm_accel

sources:
  - files:
      - src/mvm_pkg.sv
      - src/vector_fifo.sv
      - src/weight_rf.sv
      - src/inst_sequencer.sv
      - src/dpe_array.sv
      - src/tx_credit_port.sv
      - src/mvm_top.sv
  - target: test
    include_dirs:
      - sim
    files:
      - sim/tb_mvm.sv

// ==== sim/mvm_model.svh ====
mvm_pkg::inst_t model_imem [mvm_pkg::inst_depth];
mvm_pkg::vec_t model_w [mvm_pkg::lanes][mvm_pkg::rf_depth];
mvm_pkg::sum_t model_acc [mvm_pkg::lanes][mvm_pkg::acc_depth];
mvm_pkg::vec_t model_vecs [$]; // Vectors pushed and not yet consumed
mvm_pkg::result_vec_t expected [$];

function automatic void clear_model();
	foreach (model_acc[l, a])
		model_acc[l][a] = '0;
	model_vecs.delete();
	expected.delete();
endfunction

function automatic mvm_pkg::sum_t lane_dot(input mvm_pkg::vec_t v, input mvm_pkg::vec_t w);
	mvm_pkg::sum_t s;
	s = '0;
	for (int e = 0; e < mvm_pkg::elems; e++)
		s += mvm_pkg::sum_t'(v[e]) * mvm_pkg::sum_t'(w[e]); // Wraps at 32 bits
	return s;
endfunction

// Walks the program in order, the same way the sequencer issues it
function automatic void predict_run(input mvm_pkg::inst_addr_t start, input int count);
	mvm_pkg::inst_addr_t pc;
	mvm_pkg::inst_t inst;
	mvm_pkg::vec_t v;
	mvm_pkg::result_vec_t res;
	mvm_pkg::sum_t s;
	pc = start;
	for (int i = 0; i < count; i++) begin
		inst = model_imem[pc];
		v = model_vecs[0];
		for (int l = 0; l < mvm_pkg::lanes; l++) begin
			s = lane_dot(v, model_w[l][inst.rf_addr]);
			if (inst.accum_en)
				s += model_acc[l][inst.accum_addr];
			model_acc[l][inst.accum_addr] = s;
			res[l] = s;
		end
		if (inst.release_en)
			expected.push_back(res);
		if (inst.last)
			void'(model_vecs.pop_front());
		pc = pc + 1'b1;
	end
endfunction

// ==== sim/tb_mvm.sv ====
`default_nettype none

module tb_mvm;

	localparam int in_credits = 8;
	localparam int tx_credits_init = 4;

	logic clk;
	logic reset;
	logic rx_valid;
	mvm_pkg::rx_packet_t rx_packet;
	logic rx_credit;
	logic tx_valid;
	mvm_pkg::result_vec_t tx_data;
	logic tx_credit;

	int errors;
	int checks;
	int tests_run;
	int test_base;
	int rx_held; // Input credits the sender still holds
	int vec_pushed;
	int vec_returned;
	int tx_outstanding; // Granted transmit credits not yet used by a word
	logic sparse_credits;
	int unsigned seed_dummy;
	int pushed_start;
	int returned_start;

	`include "mvm_model.svh"

	mvm_top UUT (
		.clk(clk),
		.reset(reset),
		.rx_valid(rx_valid),
		.rx_packet(rx_packet),
		.rx_credit(rx_credit),
		.tx_valid(tx_valid),
		.tx_data(tx_data),
		.tx_credit(tx_credit)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	always @(negedge clk) begin
		if (reset)
			tx_credit <= 1'b0;
		else if (sparse_credits)
			tx_credit <= ($urandom % 12 == 0) && tx_outstanding < 8;
		else
			tx_credit <= tx_outstanding < tx_credits_init;
	end

	always @(posedge clk) begin
		if (!reset) begin
			if (rx_credit) begin
				rx_held++;
				vec_returned++;
			end
			if (tx_valid) begin
				checks++;
				assert (tx_outstanding > 0) else begin
					$display("tx_valid high while no transmit credit was held");
					errors++;
				end
				assert (expected.size() != 0) else begin
					$display("tx_valid high with no result expected");
					errors++;
				end
				if (expected.size() != 0) begin
					assert (tx_data === expected[0]) else begin
						$display("mismatch tx_data: got %h expected %h", tx_data, expected[0]);
						errors++;
					end
					void'(expected.pop_front());
				end
			end
			tx_outstanding = tx_outstanding + int'(tx_credit) - int'(tx_valid);
		end
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Finished with errors");
		$finish;
	endtask

	task automatic check_quiet();
		checks++;
		assert (tx_valid === 1'b0) else begin
			$display("mismatch tx_valid: got %h expected 0", tx_valid);
			errors++;
		end
		assert (rx_credit === 1'b0) else begin
			$display("mismatch rx_credit: got %h expected 0", rx_credit);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		tests_run++;
		$display("test %0d %s done with %0d errors", tests_run, name, errors - test_base);
		test_base = errors;
	endtask

	function automatic mvm_pkg::vec_t random_vec();
		mvm_pkg::vec_t v;
		for (int e = 0; e < mvm_pkg::elems; e++)
			v[e] = mvm_pkg::elem_t'($urandom);
		return v;
	endfunction

	task automatic send_packet(input mvm_pkg::rx_packet_t p);
		@(negedge clk);
		rx_valid = 1'b1;
		rx_packet = p;
		@(negedge clk);
		rx_valid = 1'b0;
	endtask

	task automatic write_inst(input mvm_pkg::inst_addr_t addr, input mvm_pkg::inst_t inst);
		mvm_pkg::rx_packet_t p;
		p = '0;
		p.kind = mvm_pkg::kind_inst;
		p.addr = addr;
		p.data[0] = mvm_pkg::elem_t'(inst);
		model_imem[addr] = inst;
		send_packet(p);
	endtask

	task automatic write_weight(input mvm_pkg::rf_addr_t row, input mvm_pkg::lane_mask_t mask,
			input mvm_pkg::vec_t v);
		mvm_pkg::rx_packet_t p;
		p.kind = mvm_pkg::kind_weight;
		p.addr = mvm_pkg::inst_addr_t'(row);
		p.lane_mask = mask;
		p.data = v;
		for (int l = 0; l < mvm_pkg::lanes; l++) begin
			if (mask[l])
				model_w[l][row] = v;
		end
		send_packet(p);
	endtask

	// Spends one input credit, so it first waits until one is held
	task automatic push_vector(input mvm_pkg::vec_t v);
		mvm_pkg::rx_packet_t p;
		int cycles;
		cycles = 0;
		while (rx_held == 0 && cycles < 2000) begin
			@(negedge clk);
			cycles++;
		end
		if (rx_held == 0)
			abort_run("timeout waiting for an input credit");
		else begin
			p = '0;
			p.kind = mvm_pkg::kind_vector;
			p.data = v;
			rx_held--;
			vec_pushed++;
			model_vecs.push_back(v);
			send_packet(p);
		end
	endtask

	task automatic start_run(input mvm_pkg::inst_addr_t start, input int count);
		mvm_pkg::rx_packet_t p;
		p = '0;
		p.kind = mvm_pkg::kind_run;
		p.addr = start;
		p.data[0] = mvm_pkg::elem_t'(count);
		predict_run(start, count);
		send_packet(p);
	endtask

	task automatic wait_results(input int limit);
		int cycles;
		cycles = 0;
		while (expected.size() != 0 && cycles < limit) begin
			@(negedge clk);
			cycles++;
		end
		if (expected.size() != 0)
			abort_run("timeout waiting for results on tx_valid");
	endtask

	// Each vector is used by one or more instructions on neighbouring rows
	task automatic run_reuse_program(input int n_vec, input int max_use);
		mvm_pkg::inst_addr_t start;
		mvm_pkg::inst_t inst;
		mvm_pkg::rf_addr_t base;
		int count;
		int uses;
		start = mvm_pkg::inst_addr_t'($urandom);
		count = 0;
		for (int v = 0; v < n_vec; v++) begin
			uses = 1 + $urandom % max_use;
			base = mvm_pkg::rf_addr_t'($urandom);
			for (int j = 0; j < uses; j++) begin
				inst.rf_addr = base + mvm_pkg::rf_addr_t'(j);
				inst.accum_addr = mvm_pkg::acc_addr_t'($urandom);
				inst.accum_en = 1'b0;
				inst.release_en = 1'b1;
				inst.last = j == uses - 1;
				write_inst(start + mvm_pkg::inst_addr_t'(count), inst);
				count++;
			end
			push_vector(random_vec());
		end
		start_run(start, count);
		wait_results(4000);
	endtask

	task automatic run_chain_program(input int n_chain);
		mvm_pkg::inst_addr_t start;
		mvm_pkg::inst_t inst;
		mvm_pkg::acc_addr_t acc;
		mvm_pkg::rf_addr_t base;
		int count;
		int len;
		start = mvm_pkg::inst_addr_t'($urandom);
		count = 0;
		for (int c = 0; c < n_chain; c++) begin
			len = 2 + $urandom % 3;
			acc = mvm_pkg::acc_addr_t'($urandom);
			base = mvm_pkg::rf_addr_t'($urandom);
			for (int j = 0; j < len; j++) begin
				inst.rf_addr = base + mvm_pkg::rf_addr_t'(j);
				inst.accum_addr = acc;
				inst.accum_en = j != 0; // The first one starts a fresh sum
				inst.release_en = j == len - 1;
				inst.last = 1'b1;
				write_inst(start + mvm_pkg::inst_addr_t'(count), inst);
				count++;
				push_vector(random_vec());
			end
		end
		start_run(start, count);
		wait_results(4000);
	endtask

	initial begin
		seed_dummy = $urandom(32'h3852);
		reset = 1'b1;
		rx_valid = 1'b0;
		rx_packet = '0;
		tx_credit = 1'b0;
		sparse_credits = 1'b0;
		errors = 0;
		checks = 0;
		tests_run = 0;
		test_base = 0;
		rx_held = in_credits;
		vec_pushed = 0;
		vec_returned = 0;
		tx_outstanding = tx_credits_init;
		clear_model();

		repeat (16) begin
			@(negedge clk);
			check_quiet();
		end
		reset = 1'b0;
		repeat (20) begin
			@(negedge clk);
			check_quiet();
		end
		end_test("reset state");

		for (int r = 0; r < mvm_pkg::rf_depth; r++)
			write_weight(mvm_pkg::rf_addr_t'(r), '1, random_vec());
		repeat (3)
			run_reuse_program(1 + $urandom % 6, 1);
		end_test("single dot products");

		repeat (4)
			run_chain_program(2);
		end_test("accumulation chains");

		pushed_start = vec_pushed;
		returned_start = vec_returned;
		repeat (24)
			write_weight(mvm_pkg::rf_addr_t'($urandom), mvm_pkg::lane_mask_t'($urandom),
				random_vec());
		repeat (3)
			run_reuse_program(4, 3);
		checks++;
		assert (vec_returned - returned_start == vec_pushed - pushed_start) else begin
			$display("mismatch rx_credit pulses: got %h expected %h",
				vec_returned - returned_start, vec_pushed - pushed_start);
			errors++;
		end
		end_test("vector reuse and lane masks");

		sparse_credits = 1'b1;
		repeat (3)
			run_reuse_program(5, 3);
		sparse_credits = 1'b0;
		end_test("transmit back-pressure");

		repeat (10)
			@(negedge clk);
		checks++;
		assert (vec_returned == vec_pushed) else begin
			$display("mismatch rx_credit total: got %h expected %h", vec_returned, vec_pushed);
			errors++;
		end
		end_test("input credits");

		$display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src/mvm_top.sv ====
`default_nettype none

module mvm_top #(
	parameter int input_depth = 8,
	parameter int output_depth = 8,
	parameter int tx_credits = 4
) (
	input wire clk,
	input wire reset,
	input wire rx_valid,
	input wire mvm_pkg::rx_packet_t rx_packet,
	output logic rx_credit,
	output logic tx_valid,
	output mvm_pkg::result_vec_t tx_data,
	input wire tx_credit
);

	logic inst_wen;
	logic weight_wen;
	logic vec_push;
	logic run_start;
	mvm_pkg::inst_t inst_wdata;
	mvm_pkg::run_count_t run_count;
	mvm_pkg::vec_t vec_head;
	logic vec_empty;
	logic vec_pop;
	mvm_pkg::rf_addr_t rf_raddr;
	mvm_pkg::issue_t issue;
	mvm_pkg::vec_t issue_vec;
	mvm_pkg::vec_t [mvm_pkg::lanes-1:0] weights;
	logic res_valid;
	logic res_release;
	mvm_pkg::result_vec_t res_data;
	logic out_room;

	assign inst_wen = rx_valid && rx_packet.kind == mvm_pkg::kind_inst;
	assign weight_wen = rx_valid && rx_packet.kind == mvm_pkg::kind_weight;
	assign vec_push = rx_valid && rx_packet.kind == mvm_pkg::kind_vector;
	assign run_start = rx_valid && rx_packet.kind == mvm_pkg::kind_run;

	// Instruction and run count both sit in element 0 of the payload
	assign inst_wdata = mvm_pkg::inst_t'(rx_packet.data[0][$bits(mvm_pkg::inst_t)-1:0]);
	assign run_count = rx_packet.data[0][$bits(mvm_pkg::run_count_t)-1:0];

	assign rx_credit = vec_pop; // Each consumed vector frees one sender credit

	vector_fifo #(
		.depth(input_depth),
		.data_t(mvm_pkg::vec_t)
	) in_fifo (
		.clk(clk),
		.reset(reset),
		.push(vec_push),
		.push_data(rx_packet.data),
		.pop(vec_pop),
		.head(vec_head),
		.empty(vec_empty)
	);

	inst_sequencer seq (
		.clk(clk),
		.reset(reset),
		.inst_wen(inst_wen),
		.inst_waddr(rx_packet.addr),
		.inst_wdata(inst_wdata),
		.run_start(run_start),
		.run_addr(rx_packet.addr),
		.run_count(run_count),
		.vec_empty(vec_empty),
		.vec_head(vec_head),
		.out_room(out_room),
		.vec_pop(vec_pop),
		.rf_raddr(rf_raddr),
		.issue(issue),
		.issue_vec(issue_vec)
	);

	weight_rf wrf (
		.clk(clk),
		.wen(weight_wen),
		.waddr(mvm_pkg::rf_addr_t'(rx_packet.addr)),
		.lane_mask(rx_packet.lane_mask),
		.wdata(rx_packet.data),
		.raddr(rf_raddr),
		.rdata(weights)
	);

	dpe_array dpe (
		.clk(clk),
		.reset(reset),
		.issue(issue),
		.issue_vec(issue_vec),
		.weights(weights),
		.res_valid(res_valid),
		.res_release(res_release),
		.res_data(res_data)
	);

	tx_credit_port #(
		.output_depth(output_depth),
		.tx_credits(tx_credits)
	) tx_port (
		.clk(clk),
		.reset(reset),
		.res_valid(res_valid),
		.res_release(res_release),
		.res_data(res_data),
		.issue_release(issue.valid && issue.release_en),
		.tx_credit(tx_credit),
		.tx_valid(tx_valid),
		.tx_data(tx_data),
		.out_room(out_room)
	);

endmodule

`default_nettype wire

// ==== src/tx_credit_port.sv ====
`default_nettype none

module tx_credit_port #(
	parameter int output_depth = 8,
	parameter int tx_credits = 4
) (
	input wire clk,
	input wire reset,
	input wire res_valid,
	input wire res_release,
	input wire mvm_pkg::result_vec_t res_data,
	input wire issue_release,
	input wire tx_credit,
	output logic tx_valid,
	output mvm_pkg::result_vec_t tx_data,
	output logic out_room
);

	localparam int rw = $clog2(output_depth + 1);

	logic [rw-1:0] reserved; // Queued results plus released ones still in the array
	mvm_pkg::credit_t credits;
	logic fifo_empty;

	vector_fifo #(
		.depth(output_depth),
		.data_t(mvm_pkg::result_vec_t)
	) out_fifo (
		.clk(clk),
		.reset(reset),
		.push(res_valid && res_release),
		.push_data(res_data),
		.pop(tx_valid),
		.head(tx_data),
		.empty(fifo_empty)
	);

	assign tx_valid = (credits != '0) && !fifo_empty;
	assign out_room = reserved < rw'(output_depth);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			reserved <= '0;
			credits <= mvm_pkg::credit_t'(tx_credits);
		end else begin
			reserved <= reserved + rw'(issue_release) - rw'(tx_valid);
			credits <= credits + mvm_pkg::credit_t'(tx_credit) - mvm_pkg::credit_t'(tx_valid);
		end
	end

endmodule

`default_nettype wire

// ==== src/dpe_array.sv ====
`default_nettype none

module dpe_array (
	input wire clk,
	input wire reset,
	input wire mvm_pkg::issue_t issue,
	input wire mvm_pkg::vec_t issue_vec,
	input wire mvm_pkg::vec_t [mvm_pkg::lanes-1:0] weights,
	output logic res_valid,
	output logic res_release,
	output mvm_pkg::result_vec_t res_data
);

	mvm_pkg::issue_t s1_issue;
	mvm_pkg::issue_t s2_issue;
	mvm_pkg::issue_t s3_issue;
	mvm_pkg::vec_t s1_vec;
	wire mvm_pkg::result_vec_t lane_sum;
	mvm_pkg::result_vec_t new_sum;
	mvm_pkg::sum_t acc_mem [mvm_pkg::lanes][mvm_pkg::acc_depth];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			s1_issue <= '0;
			s2_issue <= '0;
			s3_issue <= '0;
		end else begin
			s1_issue <= issue;
			s2_issue <= s1_issue;
			s3_issue <= s2_issue;
		end
	end

	always_ff @(posedge clk)
		s1_vec <= issue_vec;

	for (genvar l = 0; l < mvm_pkg::lanes; l++) begin : g_lane
		mvm_pkg::sum_t prod [mvm_pkg::elems];
		mvm_pkg::sum_t tree;
		mvm_pkg::sum_t sum_q;

		always_ff @(posedge clk) begin
			for (int e = 0; e < mvm_pkg::elems; e++)
				prod[e] <= mvm_pkg::sum_t'(s1_vec[e]) * mvm_pkg::sum_t'(weights[l][e]);
		end

		// Pairwise reduction, halving the number of partial sums per level
		always_comb begin
			mvm_pkg::sum_t lvl [mvm_pkg::elems];
			lvl = prod;
			for (int w = mvm_pkg::elems / 2; w > 0; w = w / 2) begin
				for (int i = 0; i < w; i++)
					lvl[i] = lvl[2 * i] + lvl[2 * i + 1];
			end
			tree = lvl[0];
		end

		always_ff @(posedge clk)
			sum_q <= tree;

		assign lane_sum[l] = sum_q;
	end

	always_comb begin
		for (int l = 0; l < mvm_pkg::lanes; l++)
			new_sum[l] = lane_sum[l] + (s3_issue.accum_en ? acc_mem[l][s3_issue.accum_addr] : '0);
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int l = 0; l < mvm_pkg::lanes; l++) begin
				for (int a = 0; a < mvm_pkg::acc_depth; a++)
					acc_mem[l][a] <= '0;
			end
			res_valid <= 1'b0;
			res_release <= 1'b0;
		end else begin
			if (s3_issue.valid) begin
				for (int l = 0; l < mvm_pkg::lanes; l++)
					acc_mem[l][s3_issue.accum_addr] <= new_sum[l];
			end
			res_valid <= s3_issue.valid;
			res_release <= s3_issue.valid && s3_issue.release_en;
		end
	end

	always_ff @(posedge clk) begin
		if (s3_issue.valid)
			res_data <= new_sum;
	end

endmodule

`default_nettype wire

// ==== src/inst_sequencer.sv ====
`default_nettype none

module inst_sequencer (
	input wire clk,
	input wire reset,
	input wire inst_wen,
	input wire mvm_pkg::inst_addr_t inst_waddr,
	input wire mvm_pkg::inst_t inst_wdata,
	input wire run_start,
	input wire mvm_pkg::inst_addr_t run_addr,
	input wire mvm_pkg::run_count_t run_count,
	input wire vec_empty,
	input wire mvm_pkg::vec_t vec_head,
	input wire out_room,
	output logic vec_pop,
	output mvm_pkg::rf_addr_t rf_raddr,
	output mvm_pkg::issue_t issue,
	output mvm_pkg::vec_t issue_vec
);

	mvm_pkg::inst_t imem [mvm_pkg::inst_depth];
	mvm_pkg::seq_state_e state;
	mvm_pkg::inst_addr_t pc;
	mvm_pkg::run_count_t remaining;
	mvm_pkg::inst_t cur;
	logic fire;

	always_ff @(posedge clk) begin
		if (inst_wen)
			imem[inst_waddr] <= inst_wdata;
	end

	assign cur = imem[pc];

	// A release needs room reserved in the output FIFO before it may issue
	assign fire = (state == mvm_pkg::seq_run) && !vec_empty && (!cur.release_en || out_room);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= mvm_pkg::seq_idle;
			pc <= '0;
			remaining <= '0;
		end else begin
			case (state)
				mvm_pkg::seq_idle: begin
					if (run_start && run_count != '0) begin
						pc <= run_addr;
						remaining <= run_count;
						state <= mvm_pkg::seq_run;
					end
				end
				mvm_pkg::seq_run: begin
					if (fire) begin
						pc <= pc + 1'b1; // Wraps around the instruction memory
						remaining <= remaining - 1'b1;
						if (remaining == mvm_pkg::run_count_t'(1))
							state <= mvm_pkg::seq_idle;
					end
				end
				default: state <= mvm_pkg::seq_idle;
			endcase
		end
	end

	always_comb begin
		issue.valid = fire;
		issue.accum_addr = cur.accum_addr;
		issue.accum_en = cur.accum_en;
		issue.release_en = cur.release_en;
	end

	assign rf_raddr = cur.rf_addr;
	assign issue_vec = vec_head;
	assign vec_pop = fire && cur.last; // Head vector is done after its last instruction

endmodule

`default_nettype wire

// ==== src/weight_rf.sv ====
`default_nettype none

module weight_rf (
	input wire clk,
	input wire wen,
	input wire mvm_pkg::rf_addr_t waddr,
	input wire mvm_pkg::lane_mask_t lane_mask,
	input wire mvm_pkg::vec_t wdata,
	input wire mvm_pkg::rf_addr_t raddr,
	output mvm_pkg::vec_t [mvm_pkg::lanes-1:0] rdata
);

	// One bank of rows per lane
	mvm_pkg::vec_t bank [mvm_pkg::lanes][mvm_pkg::rf_depth];

	always_ff @(posedge clk) begin
		for (int l = 0; l < mvm_pkg::lanes; l++) begin
			if (wen && lane_mask[l])
				bank[l][waddr] <= wdata;
			rdata[l] <= bank[l][raddr]; // Lines up with stage 1 of the array
		end
	end

endmodule

`default_nettype wire

// ==== src/vector_fifo.sv ====
`default_nettype none

module vector_fifo #(
	parameter int depth = 8,
	parameter type data_t = mvm_pkg::vec_t
) (
	input wire clk,
	input wire reset,
	input wire push,
	input wire data_t push_data,
	input wire pop,
	output data_t head,
	output logic empty
);

	localparam int aw = depth > 1 ? $clog2(depth) : 1;
	localparam int cw = $clog2(depth + 1);

	data_t mem [depth];
	logic [aw-1:0] wr_ptr;
	logic [aw-1:0] rd_ptr;
	logic [cw-1:0] count;
	logic do_pop;

	function automatic logic [aw-1:0] next_ptr(input logic [aw-1:0] ptr);
		return (ptr == aw'(depth - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign do_pop = pop && !empty;
	assign empty = count == '0;
	assign head = mem[rd_ptr]; // First word falls through

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			count <= count + cw'(push) - cw'(do_pop);
		end
	end

endmodule

`default_nettype wire

// ==== src/mvm_pkg.sv ====
`default_nettype none

package mvm_pkg;

	localparam int lanes = 4;
	localparam int elems = 8;
	localparam int rf_depth = 16;
	localparam int inst_depth = 16;
	localparam int acc_depth = 8;

	typedef logic [$clog2(rf_depth)-1:0] rf_addr_t;
	typedef logic [$clog2(inst_depth)-1:0] inst_addr_t;
	typedef logic [$clog2(acc_depth)-1:0] acc_addr_t;

	typedef logic [15:0] elem_t;
	typedef elem_t [elems-1:0] vec_t; // Input vector or one weight row
	typedef logic [31:0] sum_t;
	typedef sum_t [lanes-1:0] result_vec_t;
	typedef logic [lanes-1:0] lane_mask_t;
	typedef logic [4:0] run_count_t; // Wide enough for a run over the whole memory
	typedef logic [7:0] credit_t;

	typedef enum logic [1:0] {
		kind_inst,
		kind_weight,
		kind_vector,
		kind_run
	} rx_kind_e;

	typedef struct packed {
		rx_kind_e kind;
		inst_addr_t addr;
		lane_mask_t lane_mask;
		vec_t data;
	} rx_packet_t;

	// Lives in the low bits of an instruction-write payload
	typedef struct packed {
		rf_addr_t rf_addr;
		acc_addr_t accum_addr;
		logic accum_en;
		logic release_en;
		logic last; // Last use of the current input vector
	} inst_t;

	typedef struct packed {
		logic valid;
		acc_addr_t accum_addr;
		logic accum_en;
		logic release_en;
	} issue_t;

	typedef enum logic {
		seq_idle,
		seq_run
	} seq_state_e;

endpackage

`default_nettype wire
